//--- verilog/rename_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register rename package
// Sizes, index types and the rename core state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rename_pkg;

  // Register file and checkpoint sizes
  localparam int arf_size  = 8;
  localparam int prf_size  = 16;
  localparam int cp_size   = 4;

  // Spare physical registers held by the free list
  localparam int free_size = prf_size - arf_size;

  typedef logic [$clog2(arf_size)-1:0]  arf_index_t;
  typedef logic [$clog2(prf_size)-1:0]  prf_index_t;

  // Checkpoint slot and live checkpoint count (0 to cp_size)
  typedef logic [$clog2(cp_size)-1:0]   cp_index_t;
  typedef logic [$clog2(cp_size):0]     cp_count_t;

  // Free list entry count (0 to free_size)
  typedef logic [$clog2(free_size):0]   free_count_t;

  // Free list slot and wrapping pointer with one extra lap bit
  typedef logic [$clog2(free_size)-1:0] free_index_t;
  typedef logic [$clog2(free_size):0]   free_ptr_t;

  // Rename core state where recover lasts one cycle
  typedef enum logic {
    rat_run,
    rat_recover
  } rat_state_t;

endpackage

//--- verilog/rename_uop_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural micro-op channel
// Valid/ready link from the intake to the rename core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface rename_uop_if import rename_pkg::*; ();

  logic       valid;
  logic       ready;
  arf_index_t rs1;
  arf_index_t rs2;
  arf_index_t rd;
  logic       rd_valid;
  logic       branch;

  modport source (
    output valid, rs1, rs2, rd, rd_valid, branch,
    input  ready
  );

  modport sink (
    input  valid, rs1, rs2, rd, rd_valid, branch,
    output ready
  );

endinterface

//--- verilog/renamed_uop_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Renamed micro-op channel
// Valid/ready link from the rename core to the issue register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface renamed_uop_if import rename_pkg::*; ();

  logic       valid;
  logic       ready;
  prf_index_t prs1;
  prf_index_t prs2;
  prf_index_t prd;
  prf_index_t prev_prd;
  logic       prev_valid;
  logic       cp_valid;
  cp_index_t  cp_index;

  modport source (
    output valid, prs1, prs2, prd, prev_prd, prev_valid, cp_valid, cp_index,
    input  ready
  );

  modport sink (
    input  valid, prs1, prs2, prd, prev_prd, prev_valid, cp_valid, cp_index,
    output ready
  );

endinterface

//--- verilog/rename_intake.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename intake
// Two-entry skid buffer between the front end and the
// rename core, emptied by flush
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_intake import rename_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         in_valid,
  input  arf_index_t   in_rs1,
  input  arf_index_t   in_rs2,
  input  arf_index_t   in_rd,
  input  logic         in_rd_valid,
  input  logic         in_branch,
  output logic         in_ready,
  rename_uop_if.source uop
);

  // Packed micro-op: rs1, rs2, rd, rd_valid, branch
  logic [3*$bits(arf_index_t)+1:0] in_word, main_q, skid_q;

  logic live_q;
  logic main_valid_q;
  logic skid_valid_q;
  logic in_fire;
  logic out_fire;
  logic main_load;

  // Ready from local state only and held low for one cycle out of reset
  assign in_ready  = live_q & ~skid_valid_q;
  assign in_fire   = in_valid & in_ready;
  assign out_fire  = uop.valid & uop.ready;
  assign main_load = ~main_valid_q | out_fire;

  assign in_word   = {in_rs1, in_rs2, in_rd, in_rd_valid, in_branch};
  assign uop.valid = main_valid_q;
  assign {uop.rs1, uop.rs2, uop.rd, uop.rd_valid, uop.branch} = main_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      live_q       <= 1'b0;
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (flush) begin
        main_valid_q <= 1'b0;
        skid_valid_q <= 1'b0;
      end else if (main_load) begin
        main_valid_q <= skid_valid_q | in_fire;
        skid_valid_q <= 1'b0;
      end else if (in_fire) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  // Skid entry always drains into main first
  always_ff @(posedge clock) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : in_word;
    end
    if (!main_load && in_fire) begin
      skid_q <= in_word;
    end
  end

endmodule

//--- verilog/rename_map_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename map table
// Speculative map, circular free list and checkpoint
// storage with restore
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_map_table import rename_pkg::*; (
  input  logic       clock,
  input  logic       reset,

  // Lookup and allocation
  input  arf_index_t rs1,
  input  arf_index_t rs2,
  input  arf_index_t rd,
  input  logic       allocate,
  input  logic       take_checkpoint,
  input  cp_index_t  checkpoint_slot,

  // Recovery
  input  logic       restore,
  input  cp_index_t  restore_slot,

  // Retirement
  input  logic       release_valid,
  input  prf_index_t release_prf,

  output prf_index_t prs1,
  output prf_index_t prs2,
  output prf_index_t prev_prd,
  output prf_index_t new_prd,
  output logic       free_empty
);

  prf_index_t  map_q     [arf_size];
  prf_index_t  map_next  [arf_size];
  prf_index_t  free_list [free_size];

  // Checkpoint copies of the map and the free list head
  prf_index_t  cp_map    [cp_size][arf_size];
  free_ptr_t   cp_head   [cp_size];

  free_ptr_t   head_q;
  free_ptr_t   head_next;
  free_ptr_t   tail_q;
  free_count_t free_count;

  // Sources and previous mapping read the map before this micro-op's write
  assign prs1     = map_q[rs1];
  assign prs2     = map_q[rs2];
  assign prev_prd = map_q[rd];

  // Count falls out of the lap bit in the pointers
  assign free_count = free_count_t'(tail_q - head_q);
  assign free_empty = (free_count == '0);
  assign new_prd    = free_list[free_index_t'(head_q)];

  always_comb begin
    for (int i = 0; i < arf_size; i++) begin
      map_next[i] = map_q[i];
    end
    head_next = head_q;
    if (allocate) begin
      map_next[rd] = new_prd;
      head_next    = head_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity map, spare registers queued in order
      for (int i = 0; i < arf_size; i++) begin
        map_q[i] <= prf_index_t'(i);
      end
      for (int i = 0; i < free_size; i++) begin
        free_list[i] <= prf_index_t'(arf_size + i);
      end
      head_q <= '0;
      tail_q <= free_ptr_t'(free_size);
    end else begin
      if (restore) begin
        for (int i = 0; i < arf_size; i++) begin
          map_q[i] <= cp_map[restore_slot][i];
        end
        head_q <= cp_head[restore_slot];
      end else begin
        for (int i = 0; i < arf_size; i++) begin
          map_q[i] <= map_next[i];
        end
        head_q <= head_next;
      end

      // Returned registers join at the tail
      if (release_valid) begin
        free_list[free_index_t'(tail_q)] <= release_prf;
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  // Snapshot includes the branch's own destination update
  always_ff @(posedge clock) begin
    if (take_checkpoint) begin
      for (int i = 0; i < arf_size; i++) begin
        cp_map[checkpoint_slot][i] <= map_next[i];
      end
      cp_head[checkpoint_slot] <= head_next;
    end
  end

endmodule

//--- verilog/rename_rat.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename core
// Accept control, checkpoint ring and recovery around the
// map table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_rat import rename_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  rename_uop_if.sink     uop,
  renamed_uop_if.source  renamed,
  input  logic           retire_valid,
  input  logic           retire_prev_valid,
  input  logic           retire_branch,
  input  prf_index_t     retire_prev_prd,
  input  logic           recover,
  input  cp_index_t      recover_cp,
  output logic           flush
);

  rat_state_t state_q;
  cp_index_t  cp_head_q;
  cp_index_t  cp_head_next;
  cp_count_t  cp_count_q;
  cp_count_t  cp_count_next;
  cp_index_t  cp_slot;
  cp_index_t  recover_slot_q;
  logic       no_reg, no_slot, can_rename;
  logic       fire, take_cp, free_empty;
  prf_index_t new_prd;

  assign flush = (state_q == rat_recover);

  // Stall on missing register, missing slot, or recovery in progress
  assign no_reg     = uop.rd_valid & free_empty;
  assign no_slot    = uop.branch & (cp_count_q == cp_count_t'(cp_size));
  assign can_rename = ~no_reg & ~no_slot & ~recover & ~flush;

  assign renamed.valid = uop.valid & can_rename;
  assign uop.ready     = can_rename & renamed.ready;
  assign fire          = uop.valid & uop.ready;
  assign take_cp       = fire & uop.branch;

  // Next free slot in the ring
  assign cp_slot = cp_head_q + cp_index_t'(cp_count_q);

  always_comb begin
    cp_head_next  = cp_head_q;
    cp_count_next = cp_count_q;
    if (retire_valid && retire_branch) begin
      cp_head_next  = cp_head_q + 1'b1;
      cp_count_next = cp_count_q - 1'b1;
    end
    if (recover) begin
      // Keep everything up to and including the named slot
      cp_count_next = cp_count_t'(cp_index_t'(recover_cp - cp_head_next)) + 1'b1;
    end else if (take_cp) begin
      cp_count_next = cp_count_next + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= rat_run;
      cp_head_q  <= '0;
      cp_count_q <= '0;
    end else begin
      cp_head_q  <= cp_head_next;
      cp_count_q <= cp_count_next;
      state_q    <= recover ? rat_recover : rat_run;
    end
  end

  always_ff @(posedge clock) begin
    if (recover) begin
      recover_slot_q <= recover_cp;
    end
  end

  rename_map_table u_map_table (
    .clock           (clock),
    .reset           (reset),
    .rs1             (uop.rs1),
    .rs2             (uop.rs2),
    .rd              (uop.rd),
    .allocate        (fire & uop.rd_valid),
    .take_checkpoint (take_cp),
    .checkpoint_slot (cp_slot),
    .restore         (flush),
    .restore_slot    (recover_slot_q),
    .release_valid   (retire_valid & retire_prev_valid),
    .release_prf     (retire_prev_prd),
    .prs1            (renamed.prs1),
    .prs2            (renamed.prs2),
    .prev_prd        (renamed.prev_prd),
    .new_prd         (new_prd),
    .free_empty      (free_empty)
  );

  assign renamed.prd        = uop.rd_valid ? new_prd : '0;
  assign renamed.prev_valid = uop.rd_valid;
  assign renamed.cp_valid   = uop.branch;
  assign renamed.cp_index   = cp_slot;

endmodule

//--- verilog/rename_issue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename issue register
// Output stage with back-pressure, cleared by flush
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_issue import rename_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  renamed_uop_if.sink  renamed,
  output logic         out_valid,
  output prf_index_t   out_prs1,
  output prf_index_t   out_prs2,
  output prf_index_t   out_prd,
  output prf_index_t   out_prev_prd,
  output logic         out_prev_valid,
  output logic         out_cp_valid,
  output cp_index_t    out_cp_index,
  input  logic         out_ready
);

  // Takes a new entry when empty or draining this cycle
  assign renamed.ready = ~out_valid | out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (renamed.ready) begin
      out_valid <= renamed.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (renamed.valid && renamed.ready) begin
      out_prs1       <= renamed.prs1;
      out_prs2       <= renamed.prs2;
      out_prd        <= renamed.prd;
      out_prev_prd   <= renamed.prev_prd;
      out_prev_valid <= renamed.prev_valid;
      out_cp_valid   <= renamed.cp_valid;
      out_cp_index   <= renamed.cp_index;
    end
  end

endmodule

//--- verilog/rename_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register rename stage
// Intake, rename core and issue register in a row
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_top import rename_pkg::*; (
  input  logic       clock,
  input  logic       reset,

  input  logic       in_valid,
  output logic       in_ready,
  input  arf_index_t in_rs1,
  input  arf_index_t in_rs2,
  input  arf_index_t in_rd,
  input  logic       in_rd_valid,
  input  logic       in_branch,

  input  logic       retire_valid,
  input  prf_index_t retire_prev_prd,
  input  logic       retire_prev_valid,
  input  logic       retire_branch,

  input  logic       recover_valid,
  input  cp_index_t  recover_cp,

  output logic       out_valid,
  input  logic       out_ready,
  output prf_index_t out_prs1,
  output prf_index_t out_prs2,
  output prf_index_t out_prd,
  output prf_index_t out_prev_prd,
  output logic       out_prev_valid,
  output logic       out_cp_valid,
  output cp_index_t  out_cp_index
);

  logic flush;

  rename_uop_if  uop_bus ();
  renamed_uop_if renamed_bus ();

  rename_intake u_intake (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_rs1      (in_rs1),
    .in_rs2      (in_rs2),
    .in_rd       (in_rd),
    .in_rd_valid (in_rd_valid),
    .in_branch   (in_branch),
    .in_ready    (in_ready),
    .uop         (uop_bus.source)
  );

  rename_rat u_rat (
    .clock             (clock),
    .reset             (reset),
    .uop               (uop_bus.sink),
    .renamed           (renamed_bus.source),
    .retire_valid      (retire_valid),
    .retire_prev_valid (retire_prev_valid),
    .retire_branch     (retire_branch),
    .retire_prev_prd   (retire_prev_prd),
    .recover           (recover_valid),
    .recover_cp        (recover_cp),
    .flush             (flush)
  );

  rename_issue u_issue (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .renamed        (renamed_bus.sink),
    .out_valid      (out_valid),
    .out_prs1       (out_prs1),
    .out_prs2       (out_prs2),
    .out_prd        (out_prd),
    .out_prev_prd   (out_prev_prd),
    .out_prev_valid (out_prev_valid),
    .out_cp_valid   (out_cp_valid),
    .out_cp_index   (out_cp_index),
    .out_ready      (out_ready)
  );

endmodule

//--- testbench/rename_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename output checker
// Queues expected renamed micro-ops and compares them
// at each output handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_checker import rename_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        expect_push,
  input  logic [19:0] expect_word,
  input  logic        out_valid,
  input  logic        out_ready,
  input  prf_index_t  out_prs1,
  input  prf_index_t  out_prs2,
  input  prf_index_t  out_prd,
  input  prf_index_t  out_prev_prd,
  input  logic        out_prev_valid,
  input  logic        out_cp_valid,
  input  cp_index_t   out_cp_index,
  output int          error_count,
  output int          pending
);

  // prs1, prs2, prd, prev_prd, prev_valid, cp_valid, cp_index
  logic [19:0] expected_q [$];
  int          errors        = 0;
  int          pending_count = 0;

  assign error_count = errors;
  assign pending     = pending_count;

  task automatic check_field(input string name, input logic [3:0] got, input logic [3:0] want);
    if (got !== want) begin
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic compare_record(input logic [19:0] want);
    prf_index_t want_prs1;
    prf_index_t want_prs2;
    prf_index_t want_prd;
    prf_index_t want_prev_prd;
    logic       want_prev_valid;
    logic       want_cp_valid;
    cp_index_t  want_cp_index;
    {want_prs1, want_prs2, want_prd, want_prev_prd,
     want_prev_valid, want_cp_valid, want_cp_index} = want;
    check_field("out_prs1", out_prs1, want_prs1);
    check_field("out_prs2", out_prs2, want_prs2);
    check_field("out_prev_valid", out_prev_valid, want_prev_valid);
    // Destination fields only mean something with a destination
    if (want_prev_valid) begin
      check_field("out_prd", out_prd, want_prd);
      check_field("out_prev_prd", out_prev_prd, want_prev_prd);
    end
    check_field("out_cp_valid", out_cp_valid, want_cp_valid);
    if (want_cp_valid) begin
      check_field("out_cp_index", out_cp_index, want_cp_index);
    end
  endtask

  // Sampled mid-cycle, away from the edges where inputs move
  always @(negedge clock) begin
    if (expect_push) begin
      expected_q.push_back(expect_word);
    end
    if (reset) begin
      if (out_valid === 1'b1) begin
        $display("Output valid was high during reset at %0t", $time);
        errors++;
      end
    end else if (out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("Unexpected renamed micro-op at %0t, nothing was expected", $time);
        errors++;
      end else begin
        compare_record(expected_q.pop_front());
      end
    end
    pending_count = expected_q.size();
  end

endmodule

//--- testbench/rename_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage testbench
// Reads the pattern file, drives the DUT and feeds
// expected records to the checker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

  localparam int clock_half     = 20;
  localparam int reset_cycles   = 10;
  localparam int drive_delay    = 2;
  localparam int timeout_cycles = 200;
  localparam     pattern_file   = "testbench/rename_patterns.txt";

  logic        clock;
  logic        reset;
  logic        in_valid, in_ready, in_rd_valid, in_branch;
  arf_index_t  in_rs1, in_rs2, in_rd;
  logic        retire_valid, retire_prev_valid, retire_branch;
  prf_index_t  retire_prev_prd;
  logic        recover_valid;
  cp_index_t   recover_cp;
  logic        out_valid, out_ready, out_prev_valid, out_cp_valid;
  prf_index_t  out_prs1, out_prs2, out_prd, out_prev_prd;
  cp_index_t   out_cp_index;

  logic        exp_push;
  logic [19:0] exp_word;
  int          error_count, pending;
  int          field [12];
  int          hold_left, timeouts, tb_errors;
  logic        aborted;
  logic [31:0] rnd;

  rename_top u_dut (.*);

  rename_checker u_checker (
    .clock (clock), .reset (reset), .expect_push (exp_push), .expect_word (exp_word),
    .out_valid (out_valid), .out_ready (out_ready), .out_prs1 (out_prs1),
    .out_prs2 (out_prs2), .out_prd (out_prd), .out_prev_prd (out_prev_prd),
    .out_prev_valid (out_prev_valid), .out_cp_valid (out_cp_valid),
    .out_cp_index (out_cp_index), .error_count (error_count), .pending (pending)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_half) clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Every step of the driver goes through here, so out_ready moves once per cycle
  task automatic next_cycle();
    @(posedge clock);
    #(drive_delay);
    exp_push = 1'b0;
    if (hold_left > 0) begin
      hold_left--;
      out_ready = 1'b0;
    end else begin
      rnd       = xorshift(rnd);
      out_ready = (rnd[1:0] != 2'b00);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timeouts++;
    aborted = 1'b1;
  endtask

  task automatic do_rename(input logic expected);
    int waited;
    waited      = 0;
    in_valid    = 1'b1;
    in_rs1      = arf_index_t'(field[0]);
    in_rs2      = arf_index_t'(field[1]);
    in_rd       = arf_index_t'(field[2]);
    in_rd_valid = field[3][0];
    in_branch   = field[4][0];
    if (expected) begin
      exp_word = {field[5][3:0], field[6][3:0], field[7][3:0], field[8][3:0],
                  field[9][0], field[10][0], field[11][1:0]};
      exp_push = 1'b1;
    end
    while (!in_ready && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (!in_ready) begin
      note_timeout("the front end handshake never completed");
    end else begin
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic do_retire();
    retire_valid      = 1'b1;
    retire_prev_prd   = prf_index_t'(field[0]);
    retire_prev_valid = field[1][0];
    retire_branch     = field[2][0];
    next_cycle();
    retire_valid      = 1'b0;
    retire_prev_valid = 1'b0;
    retire_branch     = 1'b0;
  endtask

  task automatic do_recover();
    recover_valid = 1'b1;
    recover_cp    = cp_index_t'(field[0]);
    next_cycle();
    recover_valid = 1'b0;
    // Wait out the flush cycle
    next_cycle();
  endtask

  task automatic start_hold();
    hold_left = field[0];
    out_ready = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending != 0 && waited < timeout_cycles) begin
      next_cycle();
      waited++;
    end
    if (pending != 0) begin
      note_timeout("expected renamed micro-ops did not all arrive");
    end
  endtask

  initial begin
    int    fd;
    int    total_errors;
    byte   cmd;
    string line;
    string rest;
    $timeformat(-9, 0, " ns", 0);
    reset = 1'b1;
    {in_valid, in_rs1, in_rs2, in_rd, in_rd_valid, in_branch} = '0;
    {retire_valid, retire_prev_prd, retire_prev_valid, retire_branch} = '0;
    {recover_valid, recover_cp} = '0;
    out_ready = 1'b1;
    exp_push  = 1'b0;
    exp_word  = '0;
    hold_left = 0;
    timeouts  = 0;
    tb_errors = 0;
    aborted   = 1'b0;
    rnd       = 32'hc90;
    repeat (reset_cycles) @(posedge clock);
    #(drive_delay);
    if (in_ready !== 1'b0) begin
      $display("Fail at %0t: in_ready got %0b expected 0", $time, in_ready);
      tb_errors++;
    end
    reset = 1'b0;

    fd = $fopen(pattern_file, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", pattern_file);
      tb_errors++;
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cmd  = line.getc(0);
      rest = line.substr(1, line.len() - 1);
      for (int i = 0; i < 12; i++) begin
        field[i] = 0;
      end
      void'($sscanf(rest, "%d %d %d %d %d %d %d %d %d %d %d %d",
                    field[0], field[1], field[2], field[3], field[4], field[5],
                    field[6], field[7], field[8], field[9], field[10], field[11]));
      case (cmd)
        "R": do_rename(1'b1);
        "F": do_rename(1'b0);
        "T": do_retire();
        "C": do_recover();
        "H": start_hold();
        "W": wait_drain();
        default: begin
          $display("Unknown pattern command: %s", line);
          tb_errors++;
        end
      endcase
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!aborted) begin
      wait_drain();
      // Give any stray output time to show up
      repeat (8) next_cycle();
    end

    total_errors = error_count + tb_errors;
    $display("Rename run finished with %0d errors and %0d timeouts", total_errors, timeouts);
    if (total_errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/rename_patterns.txt
# R rs1 rs2 rd rd_valid branch prs1 prs2 prd prev_prd prev_valid cp_valid cp_index
# F rs1 rs2 rd rd_valid branch | T prev_prd prev_valid branch | C slot | H cycles | W
R 1 2 3 1 0 1 2 8 3 1 0 0
R 3 4 5 1 0 8 4 9 5 1 0 0
R 5 3 3 1 0 9 8 10 8 1 0 0
R 3 5 0 0 0 10 9 0 0 0 0 0
R 0 7 7 1 0 0 7 11 7 1 0 0
# Free list runs dry, the ninth waits for a retire
R 1 1 1 1 0 1 1 12 1 1 0 0
R 2 2 2 1 0 2 2 13 2 1 0 0
R 4 4 4 1 0 4 4 14 4 1 0 0
R 6 6 6 1 0 6 6 15 6 1 0 0
R 1 2 0 1 0 12 13 3 0 1 0 0
T 3 1 0
T 5 1 0
T 8 1 0
T 0 0 0
T 7 1 0
R 0 3 5 1 0 3 10 5 9 1 0 0
W
T 1 1 0
T 2 1 0
T 4 1 0
T 6 1 0
T 0 1 0
T 9 1 0
# Four checkpoints, the fifth branch waits for a branch retire
R 5 0 0 0 1 5 3 0 0 0 1 0
R 1 0 0 0 1 12 3 0 0 0 1 1
R 0 1 2 1 0 3 12 8 13 1 0 0
R 2 0 0 0 1 8 3 0 0 0 1 2
R 2 2 3 1 0 8 8 7 10 1 0 0
R 3 0 0 0 1 7 3 0 0 0 1 3
R 6 0 0 0 1 15 3 0 0 0 1 0
T 0 0 1
R 3 6 6 1 0 7 15 1 15 1 0 0
W
# Held micro-ops are flushed by the recover to slot 2
H 30
F 3 3 3 1 0
F 1 1 1 1 0
C 2
R 3 6 3 1 0 10 15 7 10 1 0 0
R 6 2 6 1 0 15 8 1 15 1 0 0
R 0 0 0 0 1 3 3 0 0 0 1 3
R 7 3 7 1 0 11 7 2 11 1 0 0
R 7 6 4 1 0 2 1 4 14 1 0 0
R 4 4 0 1 0 4 4 6 3 1 0 0
R 0 5 5 1 0 6 5 0 5 1 0 0
R 5 0 1 1 0 0 6 9 12 1 0 0
R 1 2 2 0 0 9 8 0 0 0 0 0

//--- build.f
verilog/rename_pkg.sv
verilog/rename_uop_if.sv
verilog/renamed_uop_if.sv
verilog/rename_intake.sv
verilog/rename_map_table.sv
verilog/rename_rat.sv
verilog/rename_issue.sv
verilog/rename_top.sv
testbench/rename_checker.sv
testbench/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
